/* rx_stimulus.txt */
// test fmt vc req id len stall expect crc_xor hold drain body0 body1 body2 body3
// expect 1 queues a descriptor, 0 pulses crc_error; crc_xor 0 keeps the computed crc
1 1 0 2 5 3 0 1 00000000 0 0 11111111 22222222 33333333 00000000
1 1 0 1 a 2 0 1 00000000 0 0 deadbeef 0badf00d 00000000 00000000
2 2 0 3 1 0 0 1 00000000 0 0 00000000 00000000 00000000 00000000
2 2 0 4 2 4 0 1 00000000 0 0 a5a5a5a5 5a5a5a5a 01234567 89abcdef
3 1 0 2 3 2 0 0 00000001 0 0 cafebabe 12345678 00000000 00000000
3 1 0 2 4 1 0 1 00000000 0 0 87654321 00000000 00000000 00000000
3 1 0 5 6 4 0 0 80000000 0 0 00000001 00000002 00000003 00000004
3 1 0 5 7 0 0 0 00010000 0 0 00000000 00000000 00000000 00000000
3 1 0 6 8 3 0 1 00000000 0 0 aaaa0000 0000bbbb 0c0c0c0c 00000000
4 3 1 1 9 2 0 1 00000000 0 0 10203040 50607080 00000000 00000000
4 3 2 2 b 4 0 1 00000000 0 0 f0f0f0f0 0f0f0f0f ffff0000 0000ffff
4 3 3 7 c 1 0 0 00000100 0 0 13579bdf 00000000 00000000 00000000
5 1 2 3 d 4 1 1 00000000 0 0 2468ace0 11223344 55667788 99aabbcc
5 1 1 4 e 3 1 1 00000000 0 0 fedcba98 76543210 0f1e2d3c 00000000
5 1 3 2 f 2 1 0 00000002 0 0 4b4b4b4b b4b4b4b4 00000000 00000000
5 1 0 1 0 4 1 1 00000000 0 0 00000011 00000022 00000033 00000044
6 1 0 1 1 1 0 1 00000000 1 0 a0000001 00000000 00000000 00000000
6 1 1 2 2 2 0 1 00000000 1 0 a0000002 b0000002 00000000 00000000
6 1 2 3 3 0 0 1 00000000 1 0 00000000 00000000 00000000 00000000
6 1 3 4 4 3 0 1 00000000 1 0 a0000004 b0000004 c0000004 00000000
6 1 0 5 5 2 0 1 00000000 1 0 a0000005 b0000005 00000000 00000000
6 1 1 6 6 1 0 1 00000000 0 1 a0000006 00000000 00000000 00000000
6 1 2 7 7 2 0 1 00000000 0 0 a0000007 b0000007 00000000 00000000
ff

/* files.f */
chiplet_rx_pkg.sv
flit_ingress.sv
flit_crc.sv
rx_fsm.sv
rx_buffer_mem.sv
rx_desc_fifo.sv
chiplet_rx_top.sv
chiplet_rx_assertions.sv
chiplet_rx_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert -Wno-fatal
TOP       ?= chiplet_rx_tb
FILELIST  ?= files.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* chiplet_rx_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module chiplet_rx_tb
    import chiplet_rx_pkg::*;
();

    localparam int BUF_ADDR_WIDTH = 9;
    localparam int DESC_DEPTH     = 4;
    localparam int WORDS_W        = PKT_LENGTH_WIDTH + 1;
    localparam int DESC_WIDTH     = META_WIDTH + BUF_ADDR_WIDTH + WORDS_W;
    localparam int TIMEOUT        = 2000;
    localparam int STIM_WORDS     = 512;
    localparam int REC            = 15;   // words per packet record

    logic                      clk;
    logic                      n_rst;
    logic                      flit_valid;
    logic [FLIT_WIDTH-1:0]     flit_data;
    logic                      flit_ready;
    logic [NUM_VC-1:0]         credit_return;
    logic                      rd_en;
    logic [BUF_ADDR_WIDTH-1:0] rd_addr;
    logic [FLIT_WIDTH-1:0]     rd_data;
    logic                      desc_pop;
    logic                      desc_empty;
    logic [DESC_WIDTH-1:0]     desc_data;
    logic                      crc_error;

    logic [31:0]               stim [STIM_WORDS];
    logic [31:0]               pkt_words [$];
    logic [DESC_WIDTH-1:0]     held_q [$];   // descriptors left in the fifo
    logic [BUF_ADDR_WIDTH-1:0] exp_addr;
    logic                      stall_on;
    int                        seed = 31;
    int                        burst_left;
    int                        credit_cnt [NUM_VC];
    int                        err_pulses;
    int                        errors;
    int                        test_errors;
    int                        tests_run;
    int                        tests_failed;

    chiplet_rx_top #(
        .BUF_ADDR_WIDTH (BUF_ADDR_WIDTH),
        .DESC_DEPTH     (DESC_DEPTH)
    ) i_chiplet_rx_top (
        .clk           (clk),
        .n_rst         (n_rst),
        .flit_valid    (flit_valid),
        .flit_data     (flit_data),
        .flit_ready    (flit_ready),
        .credit_return (credit_return),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .desc_pop      (desc_pop),
        .desc_empty    (desc_empty),
        .desc_data     (desc_data),
        .crc_error     (crc_error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!n_rst) begin
            for (int v = 0; v < NUM_VC; v++) begin
                credit_cnt[v] <= 0;
            end
            err_pulses <= 0;
        end else begin
            for (int v = 0; v < NUM_VC; v++) begin
                if (credit_return[v]) begin
                    credit_cnt[v] <= credit_cnt[v] + 1;
                end
            end
            if (crc_error) begin
                err_pulses <= err_pulses + 1;
            end
        end
    end

    // reflected crc-32, one bit at a time
    function automatic logic [31:0] crc_word(input logic [31:0] c, input logic [31:0] w);
        logic [31:0] r;
        logic        fb;
        r = c;
        for (int i = 0; i < 32; i++) begin
            fb = r[0] ^ w[i];
            r  = r >> 1;
            if (fb) begin
                r = r ^ 32'hEDB88320;
            end
        end
        return r;
    endfunction

    task automatic abort_run(input string what);
        $display("STOPPED at %0t ns: %s", $time, what);
        $display("Test failures found");
        $finish;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
        errors++;
        test_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("%0t ns: %s", $time, what);
        errors++;
        test_errors++;
    endtask

    // host reads in short random bursts
    task automatic drive_stall();
        if (!stall_on) begin
            rd_en = 1'b0;
        end else if (burst_left > 0) begin
            rd_en = 1'b1;
            burst_left--;
        end else if (($random(seed) & 7) == 0) begin
            rd_en      = 1'b1;
            burst_left = $random(seed) & 3;
        end else begin
            rd_en = 1'b0;
        end
        rd_addr = BUF_ADDR_WIDTH'($random(seed));
    endtask

    task automatic step();
        #1;
        drive_stall();
        @(posedge clk);
    endtask

    task automatic send_flit(input logic [31:0] w);
        int t;
        t = 0;
        #1;
        flit_valid = 1'b1;
        flit_data  = w;
        drive_stall();
        while (!flit_ready) begin   // ready only moves on an edge
            if (t == TIMEOUT) abort_run("timed out waiting for the link to take a flit");
            t++;
            @(posedge clk);
            #1;
            drive_stall();
        end
        @(posedge clk);
        #1;
        flit_valid = 1'b0;
        drive_stall();
        @(posedge clk);
    endtask

    task automatic wait_desc();
        int t;
        t = 0;
        while (desc_empty) begin
            if (t == TIMEOUT) abort_run("timed out waiting for a descriptor");
            t++;
            step();
        end
    endtask

    task automatic pop_desc();
        #1 desc_pop = 1'b1;
        @(posedge clk);
        #1 desc_pop = 1'b0;
        @(posedge clk);
    endtask

    task automatic drain_held();
        logic [DESC_WIDTH-1:0] exp;
        while (held_q.size() > 0) begin
            exp = held_q.pop_front();
            wait_desc();
            if (desc_data !== exp) report_mismatch("held descriptor", 32'(desc_data), 32'(exp));
            pop_desc();
        end
    endtask

    task automatic read_back(input logic [BUF_ADDR_WIDTH-1:0] start);
        for (int k = 0; k < pkt_words.size(); k++) begin
            #1;
            rd_en   = 1'b1;
            rd_addr = start + BUF_ADDR_WIDTH'(k);
            @(posedge clk);
            #1 rd_en = 1'b0;
            @(posedge clk);
            if (rd_data !== pkt_words[k]) report_mismatch("buffer word", rd_data, pkt_words[k]);
        end
    endtask

    task automatic run_packet(input int i);
        hdr_flit_u                 hdr;
        logic [31:0]               crc;
        logic [31:0]               xorv;
        logic [BUF_ADDR_WIDTH-1:0] start;
        logic [DESC_WIDTH-1:0]     exp_desc;
        logic                      expect_ok, hold, drain, done;
        int                        len, vc, t, delta, exp_cnt, err_before;
        int                        cred_before [NUM_VC];
        hdr.raw            = '0;
        hdr.fields.format  = stim[i+1][3:0];
        hdr.fields.vc      = stim[i+2][1:0];
        hdr.fields.req     = stim[i+3][2:0];
        hdr.fields.id      = stim[i+4][3:0];
        hdr.fields.length  = stim[i+5][PKT_LENGTH_WIDTH-1:0];
        vc        = int'(stim[i+2][1:0]);
        len       = int'(stim[i+5][PKT_LENGTH_WIDTH-1:0]);
        stall_on  = stim[i+6][0];
        expect_ok = stim[i+7][0];
        xorv      = stim[i+8];
        hold      = stim[i+9][0];
        drain     = stim[i+10][0];
        if (len > 4) abort_run("stimulus record has more than four body words");
        pkt_words = {};
        pkt_words.push_back(hdr.raw);
        crc = crc_word(32'hFFFFFFFF, hdr.raw);
        for (int b = 0; b < len; b++) begin
            pkt_words.push_back(stim[i+11+b]);
            crc = crc_word(crc, stim[i+11+b]);
        end
        pkt_words.push_back(crc ^ xorv);
        if ((xorv == 32'd0) != expect_ok) report_failure("stimulus outcome disagrees with its crc");
        for (int v = 0; v < NUM_VC; v++) begin
            cred_before[v] = credit_cnt[v];
        end
        err_before = err_pulses;
        start      = exp_addr;
        for (int n = 0; n < pkt_words.size(); n++) begin
            send_flit(pkt_words[n]);
            if (n == 0 && drain) begin
                for (int k = 0; k < 40; k++) begin
                    step();
                    if (flit_ready) report_failure("link ready while descriptor FIFO is full");
                end
                drain_held();
            end
        end
        t    = 0;
        done = 1'b0;
        while (!done) begin
            delta = 0;
            for (int v = 0; v < NUM_VC; v++) begin
                delta += credit_cnt[v] - cred_before[v];
            end
            done = (delta == len + 2) &&
                   (expect_ok ? (hold || !desc_empty) : (err_pulses != err_before));
            if (!done) begin
                if (t == TIMEOUT) abort_run("timed out waiting for the packet to complete");
                t++;
                step();
            end
        end
        repeat (3) step();   // late credit pulses
        #1;
        stall_on = 1'b0;
        rd_en    = 1'b0;
        for (int v = 0; v < NUM_VC; v++) begin
            delta   = credit_cnt[v] - cred_before[v];
            exp_cnt = (v == vc) ? len + 2 : 0;
            if (delta != exp_cnt) report_mismatch("credits", delta, exp_cnt);
        end
        if (expect_ok) begin
            exp_desc = {hdr.fields.id, hdr.fields.req, start, WORDS_W'(len + 2)};
            if (hold) begin
                held_q.push_back(exp_desc);
            end else begin
                if (desc_data !== exp_desc) report_mismatch("descriptor", 32'(desc_data),
                                                            32'(exp_desc));
                pop_desc();
                read_back(start);
            end
            exp_addr = exp_addr + BUF_ADDR_WIDTH'(len + 2);
        end else begin
            if (err_pulses - err_before != 1) report_failure("crc_error did not pulse once");
            if (held_q.size() == 0 && !desc_empty) report_failure("failed packet queued");
        end
    endtask

    task automatic finish_test(input int num);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d passed", num);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", num, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        int idx;
        int cur_test;
        n_rst      = 1'b0;
        flit_valid = 1'b0;
        flit_data  = '0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        desc_pop   = 1'b0;
        stall_on   = 1'b0;
        burst_left = 0;
        exp_addr   = '0;
        errors     = 0;
        $readmemh("rx_stimulus.txt", stim);
        repeat (10) @(posedge clk);
        #1 n_rst = 1'b1;
        @(posedge clk);
        if (flit_ready !== 1'b1) report_failure("flit_ready low after reset");
        if (credit_return !== '0) report_failure("credit pulse after reset");
        if (crc_error !== 1'b0) report_failure("crc_error high after reset");
        if (desc_empty !== 1'b1) report_failure("descriptor FIFO not empty after reset");
        cur_test = 0;
        finish_test(0);
        idx = 0;
        while (idx + REC <= STIM_WORDS && stim[idx] !== 32'hff && !$isunknown(stim[idx])) begin
            if (int'(stim[idx]) != cur_test) begin
                if (cur_test != 0) finish_test(cur_test);
                cur_test = int'(stim[idx]);
            end
            run_packet(idx);
            idx += REC;
        end
        if (held_q.size() != 0) report_failure("descriptors were never drained");
        finish_test(cur_test);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* chiplet_rx_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module chiplet_rx_assertions #(
    parameter int BUF_ADDR_WIDTH = 9
) (
    input wire                      clk,
    input wire                      n_rst,
    input wire                      buf_wen,
    input wire [BUF_ADDR_WIDTH-1:0] buf_addr,
    input wire                      buf_stall,
    input wire                      desc_push,
    input wire                      overflow,
    input wire                      crc_error
);

    // a stalled write keeps its address
    stall_holds_addr: assert property (@(posedge clk) disable iff (!n_rst)
        (buf_wen && buf_stall) |=> (buf_addr == $past(buf_addr)))
        else $error("buffer address moved during a stalled write");

    no_push_when_full: assert property (@(posedge clk) disable iff (!n_rst)
        !(desc_push && overflow))
        else $error("descriptor pushed into a full FIFO");

    no_push_on_error: assert property (@(posedge clk) disable iff (!n_rst)
        !(desc_push && crc_error))
        else $error("descriptor pushed with crc_error");

endmodule

bind rx_fsm chiplet_rx_assertions #(
    .BUF_ADDR_WIDTH (BUF_ADDR_WIDTH)
) i_chiplet_rx_assertions (
    .clk       (clk),
    .n_rst     (n_rst),
    .buf_wen   (buf_wen),
    .buf_addr  (buf_addr),
    .buf_stall (buf_stall),
    .desc_push (desc_push),
    .overflow  (overflow),
    .crc_error (crc_error)
);

`default_nettype wire

/* chiplet_rx_top.sv */
`timescale 1ns/1ns
`default_nettype none

module chiplet_rx_top
    import chiplet_rx_pkg::*;
#(
    parameter int BUF_ADDR_WIDTH = 9,
    parameter int DESC_DEPTH     = 4,
    localparam int DESC_WIDTH    = META_WIDTH + BUF_ADDR_WIDTH + PKT_LENGTH_WIDTH + 1
) (
    input  wire                       clk,
    input  wire                       n_rst,
    input  wire                       flit_valid,
    input  wire  [FLIT_WIDTH-1:0]     flit_data,
    output logic                      flit_ready,
    output logic [NUM_VC-1:0]         credit_return,
    input  wire                       rd_en,
    input  wire  [BUF_ADDR_WIDTH-1:0] rd_addr,
    output logic [FLIT_WIDTH-1:0]     rd_data,
    input  wire                       desc_pop,
    output logic                      desc_empty,
    output logic [DESC_WIDTH-1:0]     desc_data,
    output logic                      crc_error
);

    logic                      data_ready, packet_sent;
    logic [FLIT_WIDTH-1:0]     flit;
    logic [1:0]                hdr_vc;
    logic                      crc_clear, crc_update, crc_done;
    logic [FLIT_WIDTH-1:0]     crc_data;
    logic [31:0]               crc_val;
    logic                      buf_wen, buf_stall;
    logic [BUF_ADDR_WIDTH-1:0] buf_addr;
    logic [FLIT_WIDTH-1:0]     buf_wdata;
    logic                      desc_push, desc_full;
    logic [META_WIDTH-1:0]     desc_meta;
    logic [BUF_ADDR_WIDTH-1:0] desc_start;
    logic [PKT_LENGTH_WIDTH:0] desc_words;

    flit_ingress i_flit_ingress (
        .clk           (clk),
        .n_rst         (n_rst),
        .flit_valid    (flit_valid),
        .flit_data     (flit_data),
        .flit_ready    (flit_ready),
        .data_ready    (data_ready),
        .flit          (flit),
        .packet_sent   (packet_sent),
        .hdr_vc        (hdr_vc),
        .credit_return (credit_return)
    );

    flit_crc i_flit_crc (
        .clk        (clk),
        .n_rst      (n_rst),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .crc_data   (crc_data),
        .crc_val    (crc_val),
        .crc_done   (crc_done)
    );

    rx_fsm #(
        .BUF_ADDR_WIDTH (BUF_ADDR_WIDTH)
    ) i_rx_fsm (
        .clk         (clk),
        .n_rst       (n_rst),
        .data_ready  (data_ready),
        .flit        (flit),
        .packet_sent (packet_sent),
        .hdr_vc      (hdr_vc),
        .crc_clear   (crc_clear),
        .crc_update  (crc_update),
        .crc_data    (crc_data),
        .crc_val     (crc_val),
        .crc_done    (crc_done),
        .buf_wen     (buf_wen),
        .buf_addr    (buf_addr),
        .buf_wdata   (buf_wdata),
        .buf_stall   (buf_stall),
        .desc_push   (desc_push),
        .desc_meta   (desc_meta),
        .desc_start  (desc_start),
        .desc_words  (desc_words),
        .overflow    (desc_full),   // fifo back-pressure
        .crc_error   (crc_error)
    );

    rx_buffer_mem #(
        .BUF_ADDR_WIDTH (BUF_ADDR_WIDTH)
    ) i_rx_buffer_mem (
        .clk       (clk),
        .n_rst     (n_rst),
        .buf_wen   (buf_wen),
        .buf_addr  (buf_addr),
        .buf_wdata (buf_wdata),
        .buf_stall (buf_stall),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    rx_desc_fifo #(
        .DESC_DEPTH     (DESC_DEPTH),
        .BUF_ADDR_WIDTH (BUF_ADDR_WIDTH)
    ) i_rx_desc_fifo (
        .clk        (clk),
        .n_rst      (n_rst),
        .desc_push  (desc_push),
        .desc_meta  (desc_meta),
        .desc_start (desc_start),
        .desc_words (desc_words),
        .desc_pop   (desc_pop),
        .desc_data  (desc_data),
        .desc_empty (desc_empty),
        .desc_full  (desc_full)
    );

endmodule

`default_nettype wire

/* rx_desc_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module rx_desc_fifo
    import chiplet_rx_pkg::*;
#(
    parameter int DESC_DEPTH     = 4,
    parameter int BUF_ADDR_WIDTH = 9,
    localparam int DESC_WIDTH    = META_WIDTH + BUF_ADDR_WIDTH + PKT_LENGTH_WIDTH + 1
) (
    input  wire                       clk,
    input  wire                       n_rst,
    input  wire                       desc_push,
    input  wire  [META_WIDTH-1:0]     desc_meta,
    input  wire  [BUF_ADDR_WIDTH-1:0] desc_start,
    input  wire  [PKT_LENGTH_WIDTH:0] desc_words,
    input  wire                       desc_pop,
    output logic [DESC_WIDTH-1:0]     desc_data,
    output logic                      desc_empty,
    output logic                      desc_full
);

    localparam int PTR_WIDTH = (DESC_DEPTH > 1) ? $clog2(DESC_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DESC_DEPTH + 1);

    logic [DESC_WIDTH-1:0] mem [DESC_DEPTH];
    logic [PTR_WIDTH-1:0]  wr_ptr, rd_ptr;
    logic [CNT_WIDTH-1:0]  count;
    logic                  do_push, do_pop;

    function automatic logic [PTR_WIDTH-1:0] ptr_inc(logic [PTR_WIDTH-1:0] p);
        return (p == PTR_WIDTH'(DESC_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign desc_full  = (count == CNT_WIDTH'(DESC_DEPTH));
    assign desc_empty = (count == '0);
    assign do_push    = desc_push && !desc_full;
    assign do_pop     = desc_pop && !desc_empty;
    assign desc_data  = mem[rd_ptr];   // show-ahead

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= {desc_meta, desc_start, desc_words};
        end
    end

endmodule

`default_nettype wire

/* rx_buffer_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module rx_buffer_mem
    import chiplet_rx_pkg::*;
#(
    parameter int BUF_ADDR_WIDTH = 9
) (
    input  wire                       clk,
    input  wire                       n_rst,
    input  wire                       buf_wen,
    input  wire  [BUF_ADDR_WIDTH-1:0] buf_addr,
    input  wire  [FLIT_WIDTH-1:0]     buf_wdata,
    output logic                      buf_stall,
    input  wire                       rd_en,
    input  wire  [BUF_ADDR_WIDTH-1:0] rd_addr,
    output logic [FLIT_WIDTH-1:0]     rd_data
);

    logic [FLIT_WIDTH-1:0] mem [2**BUF_ADDR_WIDTH];

    assign buf_stall = rd_en;   // host read owns the port

    always_ff @(posedge clk) begin
        if (buf_wen && !buf_stall) begin
            mem[buf_addr] <= buf_wdata;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* rx_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module rx_fsm
    import chiplet_rx_pkg::*;
#(
    parameter int BUF_ADDR_WIDTH = 9
) (
    input  wire                       clk,
    input  wire                       n_rst,
    input  wire                       data_ready,
    input  wire  [FLIT_WIDTH-1:0]     flit,
    output logic                      packet_sent,
    output logic [1:0]                hdr_vc,
    output logic                      crc_clear,
    output logic                      crc_update,
    output logic [FLIT_WIDTH-1:0]     crc_data,
    input  wire  [31:0]               crc_val,
    input  wire                       crc_done,
    output logic                      buf_wen,
    output logic [BUF_ADDR_WIDTH-1:0] buf_addr,
    output logic [FLIT_WIDTH-1:0]     buf_wdata,
    input  wire                       buf_stall,
    output logic                      desc_push,
    output logic [META_WIDTH-1:0]     desc_meta,
    output logic [BUF_ADDR_WIDTH-1:0] desc_start,
    output logic [PKT_LENGTH_WIDTH:0] desc_words,
    input  wire                       overflow,
    output logic                      crc_error
);

    typedef enum logic [2:0] {
        IDLE, HEADER, CRC_WAIT, CRC_CHECK, BODY, REQ_EN
    } state_e;

    state_e                    state, next_state;
    hdr_flit_u                 flit_u, hdr_q;
    logic [PKT_LENGTH_WIDTH:0] num_flits;
    logic [PKT_LENGTH_WIDTH:0] flit_cnt, next_flit_cnt;
    logic [BUF_ADDR_WIDTH-1:0] next_addr;
    logic [BUF_ADDR_WIDTH-1:0] start_q, next_start;
    logic                      crc_pending, next_crc_pending;
    logic                      crc_match;

    assign flit_u.raw = flit;
    assign num_flits  = expected_num_flits(hdr_q);
    assign crc_match  = (crc_val == flit_u.raw);
    assign crc_data   = flit_u.raw;
    assign buf_wdata  = flit_u.raw;
    assign hdr_vc     = hdr_q.fields.vc;
    assign desc_meta  = {hdr_q.fields.id, hdr_q.fields.req};
    assign desc_start = start_q;
    assign desc_words = num_flits + 1'b1;   // plus crc flit

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state       <= IDLE;
            buf_addr    <= '0;
            start_q     <= '0;
            flit_cnt    <= '0;
            crc_pending <= 1'b0;
        end else begin
            state       <= next_state;
            buf_addr    <= next_addr;
            start_q     <= next_start;
            flit_cnt    <= next_flit_cnt;
            crc_pending <= next_crc_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (state == HEADER) begin
            hdr_q <= flit_u;
        end
    end

    always_comb begin
        next_state       = state;
        next_addr        = buf_addr;
        next_start       = start_q;
        next_flit_cnt    = flit_cnt;
        next_crc_pending = crc_pending;
        packet_sent      = 1'b0;
        crc_clear        = 1'b0;
        crc_update       = 1'b0;
        buf_wen          = 1'b0;
        desc_push        = 1'b0;
        crc_error        = 1'b0;

        case (state)
            IDLE: begin
                crc_clear = 1'b1;
                if (data_ready) begin
                    next_state = HEADER;
                end
            end
            HEADER: begin
                next_flit_cnt = '0;
                next_state    = CRC_WAIT;
            end
            CRC_WAIT: begin
                if (!crc_pending) begin
                    crc_update       = 1'b1;   // start the fold
                    next_crc_pending = 1'b1;
                end else if (crc_done) begin
                    buf_wen = 1'b1;
                    if (!buf_stall) begin
                        packet_sent      = 1'b1;
                        next_addr        = buf_addr + 1'b1;
                        next_flit_cnt    = flit_cnt + 1'b1;
                        next_crc_pending = 1'b0;
                        next_state       = BODY;
                    end
                end
            end
            BODY: begin
                if (data_ready) begin
                    if (flit_cnt == num_flits) begin
                        next_state = CRC_CHECK;   // this one is the crc flit
                    end else begin
                        next_state = CRC_WAIT;
                    end
                end
            end
            CRC_CHECK: begin
                if (!crc_match) begin
                    packet_sent = 1'b1;
                    crc_error   = 1'b1;
                    next_addr   = start_q;   // drop the packet
                    next_state  = IDLE;
                end else begin
                    buf_wen = 1'b1;
                    if (!buf_stall) begin
                        packet_sent = 1'b1;
                        next_addr   = buf_addr + 1'b1;
                        next_state  = REQ_EN;
                    end
                end
            end
            REQ_EN: begin
                if (!overflow) begin
                    desc_push  = 1'b1;
                    next_start = buf_addr;
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* flit_crc.sv */
`timescale 1ns/1ns
`default_nettype none

module flit_crc
    import chiplet_rx_pkg::*;
(
    input  wire                   clk,
    input  wire                   n_rst,
    input  wire                   crc_clear,
    input  wire                   crc_update,
    input  wire  [FLIT_WIDTH-1:0] crc_data,
    output logic [31:0]           crc_val,
    output logic                  crc_done
);

    logic [FLIT_WIDTH-9:0] rest_q;   // bytes still to fold
    logic [1:0]            step_q;
    logic                  busy_q;

    // byte 0 folds on the update edge, bytes 1..3 on the next three
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc_val  <= CRC_INIT;
            rest_q   <= '0;
            step_q   <= '0;
            busy_q   <= 1'b0;
            crc_done <= 1'b0;
        end else if (crc_clear) begin
            crc_val  <= CRC_INIT;
            step_q   <= '0;
            busy_q   <= 1'b0;
            crc_done <= 1'b0;
        end else if (crc_update && !busy_q) begin
            crc_val  <= crc_fold_byte(crc_val, crc_data[7:0]);
            rest_q   <= crc_data[FLIT_WIDTH-1:8];
            step_q   <= 2'd1;
            busy_q   <= 1'b1;
            crc_done <= 1'b0;
        end else if (busy_q) begin
            crc_val <= crc_fold_byte(crc_val, rest_q[7:0]);
            rest_q  <= rest_q >> 8;
            step_q  <= step_q + 2'd1;
            if (step_q == 2'd3) begin
                busy_q   <= 1'b0;
                crc_done <= 1'b1;   // held until next update
            end
        end
    end

endmodule

`default_nettype wire

/* flit_ingress.sv */
`timescale 1ns/1ns
`default_nettype none

module flit_ingress
    import chiplet_rx_pkg::*;
(
    input  wire                   clk,
    input  wire                   n_rst,
    input  wire                   flit_valid,
    input  wire  [FLIT_WIDTH-1:0] flit_data,
    output logic                  flit_ready,
    output logic                  data_ready,
    output logic [FLIT_WIDTH-1:0] flit,
    input  wire                   packet_sent,
    input  wire  [1:0]            hdr_vc,
    output logic [NUM_VC-1:0]     credit_return
);

    logic                  full;
    logic [FLIT_WIDTH-1:0] hold_q;

    assign flit_ready = !full;
    assign data_ready = full;
    assign flit       = hold_q;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            full          <= 1'b0;
            credit_return <= '0;
        end else begin
            if (flit_valid && !full) begin
                full <= 1'b1;
            end else if (packet_sent) begin
                full <= 1'b0;   // controller consumed it
            end
            credit_return <= '0;
            if (packet_sent) begin
                credit_return[hdr_vc] <= 1'b1;   // one credit per flit
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flit_valid && !full) begin
            hold_q <= flit_data;
        end
    end

endmodule

`default_nettype wire

/* chiplet_rx_pkg.sv */
`default_nettype none

package chiplet_rx_pkg;

    localparam int FLIT_WIDTH       = 32;
    localparam int PKT_LENGTH_WIDTH = 6;
    localparam int NUM_VC           = 4;
    localparam int META_WIDTH       = 7;    // id + req

    localparam logic [31:0] CRC_POLY = 32'hEDB88320;   // reflected crc-32
    localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

    typedef struct packed {
        logic [3:0]                  format;
        logic [1:0]                  vc;
        logic [2:0]                  req;
        logic [3:0]                  id;
        logic [12:0]                 reserved;
        logic [PKT_LENGTH_WIDTH-1:0] length;   // body flits
    } hdr_fields_t;

    typedef union packed {
        hdr_fields_t           fields;
        logic [FLIT_WIDTH-1:0] raw;
    } hdr_flit_u;

    // header plus body, crc flit not counted
    function automatic logic [PKT_LENGTH_WIDTH:0] expected_num_flits(hdr_flit_u hdr);
        return {1'b0, hdr.fields.length} + 1'b1;
    endfunction

    // folds one byte, lsb first
    function automatic logic [31:0] crc_fold_byte(logic [31:0] crc, logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

`default_nettype wire
